// File: Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_aes_core
RTL_TOP    = aes_core
FILELIST   = aes_core.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The run passes only if the log holds the pass line.
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: aes_core.f
+incdir+.
aes_math_pkg.sv
aes_ctrl_pkg.sv
aes_sbox_bank.sv
aes_key_schedule.sv
aes_round_engine.sv
aes_sequencer.sv
aes_core.sv
tb_aes_core.sv

// File: aes_core.sv
// AES-128 core top level joining sequencer, key schedule, round engine and S-box bank.
`timescale 1ns/10ps
`default_nettype none

module aes_core (
        input  logic                   eph1,
        input  logic                   rst_n,
        input  aes_ctrl_pkg::func_e    func,
        input  aes_math_pkg::block_t   text_in,
        output logic                   ready,
        output aes_ctrl_pkg::status_e  call_complete,
        output aes_math_pkg::block_t   ciphertext
);
        import aes_math_pkg::*;
        import aes_ctrl_pkg::*;

        cmd_t       cmd;
        phase_e     phase;
        round_idx_t round;
        sbox_req_t  key_req;
        sbox_req_t  round_req;
        sbox_req_t  sbox_rsp;
        block_t     round_keys [0:NUM_ROUNDS];

        // ----------------------------------------------------------------------
        // Control.
        // ----------------------------------------------------------------------
        aes_sequencer seq_i (
                .eph1          (eph1),
                .rst_n         (rst_n),
                .func          (func),
                .text_in       (text_in),
                .ready         (ready),
                .cmd           (cmd),
                .phase         (phase),
                .round         (round),
                .call_complete (call_complete)
        );

        // ----------------------------------------------------------------------
        // Datapath. Both users share one S-box bank.
        // ----------------------------------------------------------------------
        aes_key_schedule key_i (
                .eph1       (eph1),
                .rst_n      (rst_n),
                .phase      (phase),
                .round      (round),
                .cmd        (cmd),
                .sbox_req   (key_req),
                .sbox_rsp   (sbox_rsp),
                .round_keys (round_keys)
        );

        aes_round_engine eng_i (
                .eph1       (eph1),
                .rst_n      (rst_n),
                .phase      (phase),
                .round      (round),
                .cmd        (cmd),
                .round_keys (round_keys),
                .sbox_req   (round_req),
                .sbox_rsp   (sbox_rsp),
                .ciphertext (ciphertext)
        );

        aes_sbox_bank sbox_i (
                .phase     (phase),
                .key_req   (key_req),
                .round_req (round_req),
                .rsp       (sbox_rsp)
        );

endmodule

`default_nettype wire

// File: aes_ctrl_pkg.sv
// Command and status codes, command struct, sequencer phase and S-box request struct.
`default_nettype none

package aes_ctrl_pkg;

        // Function codes seen at the core input. Code 2 is reserved and runs as idle.
        typedef enum logic [1:0] {
                FUNC_IDLE    = 2'd0,
                FUNC_ENCRYPT = 2'd1,
                FUNC_KEYGEN  = 2'd3
        } func_e;

        // Completion codes, each shown for a single cycle.
        typedef enum logic [1:0] {
                ST_NONE   = 2'd0,
                ST_CIPHER = 2'd1,
                ST_KEYS   = 2'd3
        } status_e;

        // A sampled command. The data field is plaintext or cipher key, by function.
        typedef struct packed {
                func_e                func;
                aes_math_pkg::block_t data;
        } cmd_t;

        typedef enum logic [1:0] {
                PH_IDLE,
                PH_KEYGEN,
                PH_ENCRYPT
        } phase_e;

        // Sixteen byte addresses into the shared S-box, one per lane.
        typedef struct packed {
                aes_math_pkg::block_t lane;
        } sbox_req_t;

endpackage

`default_nettype wire

// File: aes_key_schedule.sv
// Round key generator with the eleven-entry round key store.
`timescale 1ns/10ps
`default_nettype none

module aes_key_schedule (
        input  logic                      eph1,
        input  logic                      rst_n,
        input  aes_ctrl_pkg::phase_e      phase,
        input  aes_math_pkg::round_idx_t  round,
        input  aes_ctrl_pkg::cmd_t        cmd,
        output aes_ctrl_pkg::sbox_req_t   sbox_req,
        input  aes_ctrl_pkg::sbox_req_t   sbox_rsp,
        output aes_math_pkg::block_t      round_keys [0:aes_math_pkg::NUM_ROUNDS]
);
        import aes_math_pkg::*;
        import aes_ctrl_pkg::*;

        round_idx_t  prev_idx;
        word_t [3:0] prev_w;
        word_t [3:0] next_w;
        word_t       g_word;
        byte_t       rcon;

        // ----------------------------------------------------------------------
        // g function.
        // ----------------------------------------------------------------------
        // Each new key is built from the key one round back. Word 3 of the array
        // is the first key word, word 0 the last.
        assign prev_idx = (round == 4'd0) ? 4'd0 : round - 4'd1;
        assign prev_w   = round_keys[prev_idx];

        // The rotated last word goes out through the shared S-box bank.
        assign sbox_req.lane = {96'd0, rot_word(prev_w[0])};

        // The round constant only touches the leading byte of the word.
        assign g_word = sbox_rsp.lane[3:0] ^ {rcon, 24'd0};

        // ----------------------------------------------------------------------
        // Word chain.
        // ----------------------------------------------------------------------
        // The first word takes g, and every later word folds in the new word
        // just before it.
        always_comb begin
                next_w[3] = prev_w[3] ^ g_word;
                for (int i = 2; i >= 0; i--) begin
                        next_w[i] = prev_w[i] ^ next_w[i + 1];
                end
        end

        // ----------------------------------------------------------------------
        // Key store and round constant.
        // ----------------------------------------------------------------------
        // Round 0 stores the cipher key as given. Rounds 1 to 10 store one
        // derived key per cycle, indexed by round number.
        always_ff @(posedge eph1) begin
                if (!rst_n) begin
                        for (int i = 0; i <= NUM_ROUNDS; i++) begin
                                round_keys[i] <= '0;
                        end
                        rcon <= RCON_FIRST;
                end else if (phase == PH_KEYGEN) begin
                        if (round == 4'd0) begin
                                round_keys[0] <= cmd.data;
                                rcon          <= RCON_FIRST;
                        end else begin
                                round_keys[round] <= next_w;
                                rcon              <= next_rcon(rcon);
                        end
                end
        end

        // The constant shifts left ten times in a row. Without the wrap to
        // 8'h1b it would run out to zero before round 10.
        a_rcon_live: assert property (@(posedge eph1) disable iff (!rst_n)
                (phase == PH_KEYGEN) |-> (rcon != 8'h00))
                else $error("Round constant reached zero during key expansion");

endmodule

`default_nettype wire

// File: aes_math_pkg.sv
// Datapath types, round constant rule, GF(2^8) helpers and ShiftRows for the AES-128 core.
`default_nettype none

package aes_math_pkg;

        // ----------------------------------------------------------------------
        // Types. A block is sixteen bytes in column-major order, byte 15 first.
        // ----------------------------------------------------------------------
        typedef logic [7:0]   byte_t;
        typedef byte_t [3:0]  word_t;
        typedef byte_t [15:0] block_t;
        typedef logic [3:0]   round_idx_t;

        localparam round_idx_t NUM_ROUNDS = 4'd10;

        // Reduction polynomial x^8 + x^4 + x^3 + x + 1 without its top bit.
        localparam byte_t GF_POLY    = 8'h1b;
        localparam byte_t RCON_FIRST = 8'h01;
        // The round constant leaves 8 bits after 8'h80 and is reduced by the polynomial.
        localparam byte_t RCON_WRAP  = GF_POLY;

        // ----------------------------------------------------------------------
        // GF(2^8) arithmetic.
        // ----------------------------------------------------------------------
        function automatic byte_t xtime2(input byte_t x);
                return {x[6:0], 1'b0} ^ (x[7] ? GF_POLY : 8'h00);
        endfunction

        // Multiply by 3 is multiply by 2 plus the operand itself.
        function automatic byte_t xtime3(input byte_t x);
                return xtime2(x) ^ x;
        endfunction

        // Round constant for the next key round.
        function automatic byte_t next_rcon(input byte_t rcon);
                return (rcon == 8'h80) ? RCON_WRAP : {rcon[6:0], 1'b0};
        endfunction

        // ----------------------------------------------------------------------
        // Byte permutations.
        // ----------------------------------------------------------------------
        // Row r of the state rotates left by r columns. Byte (row r, column c)
        // sits at index 15 - 4c - r.
        function automatic block_t shift_rows(input block_t s);
                block_t t;
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                t[15 - 4 * c - r] = s[15 - 4 * ((c + r) % 4) - r];
                        end
                end
                return t;
        endfunction

        // One-byte left rotation of a key word, as used by the g function.
        function automatic word_t rot_word(input word_t w);
                return {w[2:0], w[3]};
        endfunction

endpackage

`default_nettype wire

// File: aes_round_engine.sv
// Iterative encryption datapath with state register, ShiftRows, MixColumns and AddRoundKey.
`timescale 1ns/10ps
`default_nettype none

module aes_round_engine (
        input  logic                      eph1,
        input  logic                      rst_n,
        input  aes_ctrl_pkg::phase_e      phase,
        input  aes_math_pkg::round_idx_t  round,
        input  aes_ctrl_pkg::cmd_t        cmd,
        input  aes_math_pkg::block_t      round_keys [0:aes_math_pkg::NUM_ROUNDS],
        output aes_ctrl_pkg::sbox_req_t   sbox_req,
        input  aes_ctrl_pkg::sbox_req_t   sbox_rsp,
        output aes_math_pkg::block_t      ciphertext
);
        import aes_math_pkg::*;
        import aes_ctrl_pkg::*;

        block_t      state;
        block_t      round_in;
        block_t      shifted;
        block_t      round_out;
        word_t [3:0] cols_in;
        word_t [3:0] cols_out;

        // One column times the fixed MixColumns matrix. Index 3 holds row 0.
        function automatic word_t mix_column(input word_t a);
                word_t m;
                for (int r = 0; r < 4; r++) begin
                        m[3 - r] = xtime2(a[3 - r]) ^ xtime3(a[(6 - r) % 4]) ^
                                   a[(5 - r) % 4] ^ a[(4 - r) % 4];
                end
                return m;
        endfunction

        // ----------------------------------------------------------------------
        // Round input and SubBytes.
        // ----------------------------------------------------------------------
        // Round 1 starts from the plaintext whitened with key 0. Later rounds
        // recycle the state register.
        assign round_in = (round == 4'd1) ? (cmd.data ^ round_keys[0]) : state;

        // SubBytes is done by the shared bank, all sixteen lanes at once.
        assign sbox_req.lane = round_in;

        // ----------------------------------------------------------------------
        // ShiftRows, MixColumns and AddRoundKey.
        // ----------------------------------------------------------------------
        assign shifted = shift_rows(sbox_rsp.lane);
        assign cols_in = shifted;

        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        cols_out[c] = mix_column(cols_in[c]);
                end
        end

        // The last round leaves out MixColumns.
        assign round_out = ((round == NUM_ROUNDS) ? shifted : block_t'(cols_out)) ^
                           round_keys[round];

        // The state advances one round per cycle and holds outside encryption,
        // so the ciphertext stays put until the next encrypt starts.
        always_ff @(posedge eph1) begin
                if (!rst_n) begin
                        state <= '0;
                end else if (phase == PH_ENCRYPT) begin
                        state <= round_out;
                end
        end

        assign ciphertext = state;

endmodule

`default_nettype wire

// File: aes_sbox_bank.sv
// Shared bank of sixteen S-box lookups with phase-based choice of requester.
`timescale 1ns/10ps
`default_nettype none

module aes_sbox_bank (
        input  aes_ctrl_pkg::phase_e    phase,
        input  aes_ctrl_pkg::sbox_req_t key_req,
        input  aes_ctrl_pkg::sbox_req_t round_req,
        output aes_ctrl_pkg::sbox_req_t rsp
);
        import aes_ctrl_pkg::*;

        `include "aes_sbox_table.svh"

        sbox_req_t sel;

        // ----------------------------------------------------------------------
        // Arbitration.
        // ----------------------------------------------------------------------
        // Key expansion and encryption never overlap, so the phase alone picks
        // the owner. The key schedule only reads back lanes 3 to 0, and it
        // drives its upper lanes to zero.
        assign sel = (phase == PH_KEYGEN) ? key_req : round_req;

        // Pure table lookups, no state.
        always_comb begin
                for (int i = 0; i < 16; i++) begin
                        rsp.lane[i] = SBOX_TABLE[sel.lane[i]];
                end
        end

endmodule

`default_nettype wire

// File: aes_sbox_table.svh
// Forward AES S-box as one packed constant, entry 0 in the top byte.
`ifndef AES_SBOX_TABLE_SVH
`define AES_SBOX_TABLE_SVH

// Each literal is one row of the FIPS-197 table, sixteen entries wide.
// The ascending range lets a plain byte value index the table directly.
localparam logic [0:255][7:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
};

`endif

// File: aes_sequencer.sv
// Command register, phase FSM, round counter, ready and completion status.
`timescale 1ns/10ps
`default_nettype none

module aes_sequencer (
        input  logic                      eph1,
        input  logic                      rst_n,
        input  aes_ctrl_pkg::func_e       func,
        input  aes_math_pkg::block_t      text_in,
        output logic                      ready,
        output aes_ctrl_pkg::cmd_t        cmd,
        output aes_ctrl_pkg::phase_e      phase,
        output aes_math_pkg::round_idx_t  round,
        output aes_ctrl_pkg::status_e     call_complete
);
        import aes_math_pkg::*;
        import aes_ctrl_pkg::*;

        phase_e     state;
        phase_e     start_phase;
        round_idx_t cnt;
        status_e    done_code;

        // ----------------------------------------------------------------------
        // Command sampling and phase FSM.
        // ----------------------------------------------------------------------
        // Reserved and idle codes both leave the FSM idle.
        always_comb begin
                case (func)
                        FUNC_ENCRYPT: start_phase = PH_ENCRYPT;
                        FUNC_KEYGEN:  start_phase = PH_KEYGEN;
                        default:      start_phase = PH_IDLE;
                endcase
        end

        // The core takes a command while idle and in the last cycle of a
        // phase, which is what lets commands stream with no gap.
        assign ready = (state == PH_IDLE) || (cnt == 4'd0);

        // Key expansion runs 11 cycles (key 0 to key 10) and encryption 10
        // (rounds 1 to 10), counted down to zero.
        always_ff @(posedge eph1) begin
                if (!rst_n) begin
                        cmd   <= '0;
                        state <= PH_IDLE;
                        cnt   <= '0;
                end else if (ready) begin
                        cmd.func <= func;
                        cmd.data <= text_in;
                        state    <= start_phase;
                        cnt      <= (start_phase == PH_KEYGEN) ? NUM_ROUNDS :
                                                                 NUM_ROUNDS - 4'd1;
                end else begin
                        cnt <= cnt - 4'd1;
                end
        end

        // ----------------------------------------------------------------------
        // Datapath phase, round number and status.
        // ----------------------------------------------------------------------
        // The datapath trails the FSM by one cycle. It reads the command in its
        // first round, before the next command can land in the register.
        assign done_code = (round != NUM_ROUNDS)   ? ST_NONE   :
                           (phase == PH_KEYGEN)    ? ST_KEYS   :
                           (phase == PH_ENCRYPT)   ? ST_CIPHER : ST_NONE;

        always_ff @(posedge eph1) begin
                if (!rst_n) begin
                        phase         <= PH_IDLE;
                        round         <= '0;
                        call_complete <= ST_NONE;
                end else begin
                        phase         <= state;
                        round         <= (state == PH_IDLE) ? 4'd0 : NUM_ROUNDS - cnt;
                        call_complete <= done_code;
                end
        end

        // Results are one-cycle pulses, so ST_CIPHER and ST_KEYS can never
        // show up back to back.
        a_status_pulse: assert property (@(posedge eph1) disable iff (!rst_n)
                (call_complete != ST_NONE) |=> (call_complete == ST_NONE))
                else $error("Completion status held longer than one cycle");

        a_round_range: assert property (@(posedge eph1) disable iff (!rst_n)
                round <= NUM_ROUNDS)
                else $error("Round index ran past the last round key");

endmodule

`default_nettype wire

// File: tb_aes_core.sv
// Self-checking testbench for the AES-128 core with FIPS-197 vectors and a watchdog.
`timescale 1ns/10ps
`default_nettype none

module tb_aes_core;
        import aes_math_pkg::*;
        import aes_ctrl_pkg::*;

        localparam int CLK_PERIOD      = 8;
        localparam int RESET_CYCLES    = 16;
        // Sampling edge to the completion pulse.
        localparam int KEYGEN_LATENCY  = 12;
        localparam int ENCRYPT_LATENCY = 11;
        // Cycles with ready low after a sample, before the last cycle of the phase.
        localparam logic [3:0] KEYGEN_BUSY  = 4'd10;
        localparam logic [3:0] ENCRYPT_BUSY = 4'd9;
        localparam int NUM_CMDS        = 8;
        localparam int NUM_GAPS        = 5;
        localparam int MAX_GAP         = 4;
        localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CMDS * 14 + NUM_GAPS * MAX_GAP;

        // FIPS-197 appendix C.1 and appendix B vectors.
        localparam block_t KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
        localparam block_t PT_A  = 128'h00112233445566778899aabbccddeeff;
        localparam block_t CT_A  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        localparam block_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        localparam block_t PT_B  = 128'h3243f6a8885a308d313198a2e0370734;
        localparam block_t CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;

        logic                     eph1;
        logic                     rst_n;
        func_e                    func;
        block_t                   text_in;
        logic                     ready;
        status_e                  call_complete;
        block_t                   ciphertext;

        integer                   seed;
        int                       mismatch_count;
        int                       failure_count;
        int                       cipher_seen;
        logic                     take_keys;
        logic                     take_text;
        logic [KEYGEN_LATENCY:0]  keys_due;
        logic [ENCRYPT_LATENCY:0] cipher_due;
        logic [3:0]               ready_in;
        status_e                  exp_status;
        block_t                   exp_next;
        block_t                   exp_ct [0:15];
        block_t                   exp_cipher;
        logic [3:0]               push_idx;
        logic [3:0]               pop_idx;

        aes_core dut_i (
                .eph1          (eph1),
                .rst_n         (rst_n),
                .func          (func),
                .text_in       (text_in),
                .ready         (ready),
                .call_complete (call_complete),
                .ciphertext    (ciphertext)
        );

        always #(CLK_PERIOD / 2) eph1 = ~eph1;

        // ------------------------------------------------------------------
        // Reference timing model.
        // ------------------------------------------------------------------
        // A command is taken at an edge where ready is high. Each taken command
        // walks a one-hot delay line, and its tap gives the expected status.
        assign take_keys = ready && (func == FUNC_KEYGEN);
        assign take_text = ready && (func == FUNC_ENCRYPT);

        // Oldest ciphertext still waiting for its report.
        assign exp_cipher = exp_ct[pop_idx];

        always_comb begin
                if (keys_due[KEYGEN_LATENCY])
                        exp_status = ST_KEYS;
                else if (cipher_due[ENCRYPT_LATENCY])
                        exp_status = ST_CIPHER;
                else
                        exp_status = ST_NONE;
        end

        always @(posedge eph1) begin
                if (!rst_n) begin
                        keys_due    <= '0;
                        cipher_due  <= '0;
                        ready_in    <= 4'd0;
                        push_idx    <= 4'd0;
                        pop_idx     <= 4'd0;
                        cipher_seen <= 0;
                end else begin
                        keys_due   <= {keys_due[KEYGEN_LATENCY-1:0], take_keys};
                        cipher_due <= {cipher_due[ENCRYPT_LATENCY-1:0], take_text};
                        if (take_keys)
                                ready_in <= KEYGEN_BUSY;
                        else if (take_text)
                                ready_in <= ENCRYPT_BUSY;
                        else if (ready_in != 4'd0)
                                ready_in <= ready_in - 4'd1;
                        // Expected ciphertexts queue up in command order.
                        if (take_text) begin
                                exp_ct[push_idx] <= exp_next;
                                push_idx         <= push_idx + 4'd1;
                        end
                        if (cipher_due[ENCRYPT_LATENCY])
                                pop_idx <= pop_idx + 4'd1;
                        // Cipher reports as the core gives them.
                        if (call_complete == ST_CIPHER)
                                cipher_seen <= cipher_seen + 1;
                end
        end

        // ------------------------------------------------------------------
        // Checks.
        // ------------------------------------------------------------------
        a_status: assert property (@(posedge eph1) disable iff (!rst_n)
                call_complete == exp_status)
                else begin
                        mismatch_count++;
                        $display("Mismatch at %0t: call_complete is %0d, expected %0d",
                                 $time, $sampled(call_complete), $sampled(exp_status));
                end

        a_ready: assert property (@(posedge eph1) disable iff (!rst_n)
                ready == (ready_in == 4'd0))
                else begin
                        mismatch_count++;
                        $display("Mismatch at %0t: ready is %0b, expected %0b",
                                 $time, $sampled(ready), $sampled(ready_in) == 4'd0);
                end

        a_cipher: assert property (@(posedge eph1) disable iff (!rst_n)
                cipher_due[ENCRYPT_LATENCY] |-> (ciphertext == exp_cipher))
                else begin
                        mismatch_count++;
                        $display("Mismatch at %0t: ciphertext is %h, expected %h",
                                 $time, $sampled(ciphertext), $sampled(exp_cipher));
                end

        // Outside encryption the last result must hold.
        a_hold: assert property (@(posedge eph1) disable iff (!rst_n)
                (cipher_due == '0) |-> $stable(ciphertext))
                else begin
                        mismatch_count++;
                        $display("Mismatch at %0t: ciphertext changed with no encryption running",
                                 $time);
                end

        // ------------------------------------------------------------------
        // Stimulus.
        // ------------------------------------------------------------------
        // Every task starts and ends 1 ns after a rising edge.
        task automatic step(input int n);
                repeat (n) @(posedge eph1);
                #1;
        endtask

        // Present a command until an edge with ready high takes it.
        task automatic issue(input func_e f, input block_t data, input block_t expect_ct);
                func     = f;
                text_in  = data;
                exp_next = expect_ct;
                while (!ready)
                        step(1);
                step(1);
                func = FUNC_IDLE;
        endtask

        task automatic wait_done();
                while (keys_due != '0 || cipher_due != '0)
                        step(1);
        endtask

        task automatic idle_gap();
                int gap;
                gap = 1 + ($unsigned($random(seed)) % MAX_GAP);
                step(gap);
        endtask

        initial begin
                seed           = 32'h9be20291;
                mismatch_count = 0;
                failure_count  = 0;
                eph1           = 1'b0;
                rst_n          = 1'b0;
                func           = FUNC_IDLE;
                text_in        = '0;
                exp_next       = '0;
                step(RESET_CYCLES);
                rst_n = 1'b1;
                idle_gap();
                issue(FUNC_KEYGEN, KEY_A, '0);
                wait_done();
                idle_gap();
                issue(FUNC_ENCRYPT, PT_A, CT_A);
                wait_done();
                idle_gap();
                // Two encrypts streamed at ready.
                issue(FUNC_ENCRYPT, PT_A, CT_A);
                issue(FUNC_ENCRYPT, PT_A, CT_A);
                wait_done();
                idle_gap();
                // Re-key and encrypt back to back, then switch back to the first key.
                issue(FUNC_KEYGEN, KEY_B, '0);
                issue(FUNC_ENCRYPT, PT_B, CT_B);
                wait_done();
                idle_gap();
                issue(FUNC_KEYGEN, KEY_A, '0);
                issue(FUNC_ENCRYPT, PT_A, CT_A);
                wait_done();
                step(4);
                if (cipher_seen != push_idx) begin
                        failure_count++;
                        $display("Not every encrypt command reported a ciphertext");
                end
                $display("Errors: %0d mismatches, %0d other failures",
                         mismatch_count, failure_count);
                if (mismatch_count == 0 && failure_count == 0)
                        $display("TEST OK");
                else
                        $display("TEST FAILED");
                $finish;
        end

        initial begin
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                failure_count++;
                $display("Timeout: the command sequence did not finish within %0d cycles",
                         WATCHDOG_CYCLES);
                $display("Errors: %0d mismatches, %0d other failures",
                         mismatch_count, failure_count);
                $display("TEST FAILED");
                $finish;
        end

endmodule

`default_nettype wire
